//--- common/cpuctrl_cfg.svh
`ifndef CPUCTRL_CFG_SVH
`define CPUCTRL_CFG_SVH

// ----------------------------------------
// bus widths
// ----------------------------------------
// processor address, full 16 bits
`define CFG_ADDR_BITS 16
// one data word
`define CFG_DATA_BITS 16

// ----------------------------------------
// memory sizes
// ----------------------------------------
// 512 ram words, upper address bits wrap
`define CFG_RAM_ADDR_BITS 9
// 64 boot words
`define CFG_ROM_ADDR_BITS 6
`define CFG_ROM_WORDS (1 << `CFG_ROM_ADDR_BITS)

// ----------------------------------------
// access timing
// ----------------------------------------
// extra wait cycles after a read
`define CFG_READ_CYCLES 1
// extra cycles the write enable is held
`define CFG_WRITE_CYCLES 2

// watched location, lands on ram word 1ff
`define CFG_WATCH_ADDR 16'h03ff

`endif

//--- common/mem_pkg.sv
`include "cpuctrl_cfg.svh"

package mem_pkg;

	// ----------------------------------------
	// basic words
	// ----------------------------------------
	// data word
	typedef logic [`CFG_DATA_BITS-1:0] word_t;
	// processor address
	typedef logic [`CFG_ADDR_BITS-1:0] addr_t;
	// ram word index after wrapping
	typedef logic [`CFG_RAM_ADDR_BITS-1:0] ram_addr_t;
	// boot rom word index
	typedef logic [`CFG_ROM_ADDR_BITS-1:0] rom_addr_t;

	// ----------------------------------------
	// bundles
	// ----------------------------------------
	// one processor request, held until ready
	typedef struct packed {
		addr_t addr;
		word_t wdata;
		// 1 for a write, 0 for a read
		logic  write;
	} mem_req_t;

	// drive of the ram read-write port
	typedef struct packed {
		ram_addr_t addr;
		word_t     data;
		logic      we;
	} ram_port_t;

endpackage

//--- common/sys_pkg.sv
package sys_pkg;

	// ----------------------------------------
	// boot sequence
	// ----------------------------------------
	// reset, copy rom, then hand ram to the processor
	typedef enum logic [1:0] {
		RESET_ALL,
		COPY_ROM,
		RUN_CPU
	} sys_state_t;

	// ----------------------------------------
	// processor access
	// ----------------------------------------
	// idle, wait on read data, latch write data, hold the write
	typedef enum logic [1:0] {
		ACC_IDLE,
		ACC_READ_WAIT,
		ACC_PREPARE_WRITE,
		ACC_WRITE
	} access_state_t;

	// status seen from outside
	typedef struct packed {
		sys_state_t state;
		// high while a write is held on the ram
		logic       writing;
	} sys_status_t;

endpackage

//--- memory/ram_2port.sv
`timescale 1ns/1ns
`include "cpuctrl_cfg.svh"

module ram_2port #(
	parameter int addr_bits = `CFG_RAM_ADDR_BITS,
	parameter int data_bits = `CFG_DATA_BITS
) (
	input  logic                 clock,

	// port 1, read and write
	input  mem_pkg::ram_port_t   port1,
	output mem_pkg::word_t       rdata1,

	// port 2, read only
	input  logic [addr_bits-1:0] addr2,
	output mem_pkg::word_t       rdata2
);

	localparam int num_words = 1 << addr_bits;

	// storage, contents survive reset
	logic [data_bits-1:0] mem [num_words];

	// ----------------------------------------
	// port 1
	// ----------------------------------------
	// read-first, old word comes out on a write
	always_ff @(posedge clock) begin
		rdata1 <= mem[port1.addr];
		if (port1.we) begin
			mem[port1.addr] <= port1.data;
		end
	end

	// ----------------------------------------
	// port 2
	// ----------------------------------------
	// registered read like port 1
	always_ff @(posedge clock) begin
		rdata2 <= mem[addr2];
	end

	// the port 1 driver upstream must never leave the enable floating
	assert property (@(posedge clock) !$isunknown(port1.we))
		else $error("ram_2port: port 1 write enable unknown");

endmodule

//--- memory/boot_rom.sv
`timescale 1ns/1ns
`include "cpuctrl_cfg.svh"

module boot_rom (
	input  mem_pkg::rom_addr_t addr,
	output mem_pkg::word_t     data
);

	import mem_pkg::*;

	localparam int num_words = `CFG_ROM_WORDS;
	// width of one byte lane of the word
	localparam int half_bits = `CFG_DATA_BITS / 2;

	// whole image as one packed table
	typedef word_t [num_words-1:0] image_t;

	// ----------------------------------------
	// image rule
	// ----------------------------------------
	// high byte the address
	// low byte the inverted address
	function automatic image_t build_image();
		image_t image;
		logic [half_bits-1:0] tag;
		for (int i = 0; i < num_words; i++) begin
			tag = half_bits'(i);
			image[i] = {tag, ~tag};
		end
		return image;
	endfunction

	// fixed at elaboration, stands in for a program image
	localparam image_t boot_image = build_image();

	// no clock, word comes straight out
	always_comb begin
		data = boot_image[addr];
	end

endmodule

//--- memory/memcpy.sv
`timescale 1ns/1ns
`include "cpuctrl_cfg.svh"

module memcpy #(
	parameter int num_words = `CFG_ROM_WORDS
) (
	input  logic                         clock,
	input  logic                         reset,

	// rom side
	output logic [$clog2(num_words)-1:0] rom_addr,
	input  mem_pkg::word_t               rom_data,

	// ram side
	output mem_pkg::ram_port_t           ram,

	// high once every word is in ram
	output logic                         finished
);

	import mem_pkg::*;

	localparam int count_bits = $clog2(num_words);

	// word being copied this cycle
	logic [count_bits-1:0] count;
	logic                  last_word;

	assign last_word = (count == count_bits'(num_words - 1));

	// ----------------------------------------
	// word counter
	// ----------------------------------------
	always_ff @(posedge clock) begin
		if (reset) begin
			count    <= '0;
			finished <= 1'b0;
		end else if (!finished) begin
			// done after the last write while the counter stays put
			if (last_word) begin
				finished <= 1'b1;
			end else begin
				count <= count + 1'b1;
			end
		end
	end

	// ----------------------------------------
	// rom to ram
	// ----------------------------------------
	// rom answers at once so the write goes out in the same cycle
	assign rom_addr = count;

	always_comb begin
		ram.addr = ram_addr_t'(count);
		ram.data = rom_data;
		ram.we   = !finished;
	end

	// the rom must hand over a known word for every copy
	assert property (@(posedge clock) disable iff (reset)
		ram.we |-> !$isunknown(rom_data))
		else $error("memcpy: unknown rom word copied");

endmodule

//--- source/mem_access.sv
`timescale 1ns/1ns
`include "cpuctrl_cfg.svh"

module mem_access (
	input  logic               clock,
	input  logic               reset,
	// high only while the processor owns the ram
	input  logic               enable,

	// processor request port
	input  mem_pkg::mem_req_t  req,
	input  logic               req_valid,
	output logic               req_ready,

	// ram port 1
	output mem_pkg::ram_port_t ram,
	input  mem_pkg::word_t     ram_rdata,

	output mem_pkg::word_t     rsp_data,
	output mem_pkg::word_t     watch_data,
	output logic               writing
);

	import mem_pkg::*;
	import sys_pkg::*;

	localparam int read_bits  = $clog2(`CFG_READ_CYCLES + 1);
	localparam int write_bits = $clog2(`CFG_WRITE_CYCLES + 1);
	// watch address after wrapping into the ram
	localparam ram_addr_t watch_addr = ram_addr_t'(`CFG_WATCH_ADDR);

	access_state_t         state;
	access_state_t         next_state;
	logic [read_bits-1:0]  read_cycle;
	logic [write_bits-1:0] write_cycle;
	logic                  read_done;
	logic                  write_done;
	word_t                 write_data;
	ram_addr_t             req_ram_addr;

	// upper address bits dropped
	assign req_ram_addr = ram_addr_t'(req.addr);

	assign read_done  = (read_cycle == read_bits'(`CFG_READ_CYCLES));
	assign write_done = (write_cycle == write_bits'(`CFG_WRITE_CYCLES));

	// ----------------------------------------
	// state and counters
	// ----------------------------------------
	always_ff @(posedge clock) begin
		if (reset) begin
			state       <= ACC_IDLE;
			read_cycle  <= '0;
			write_cycle <= '0;
			watch_data  <= '0;
		end else begin
			state <= next_state;

			// counts only while waiting on read data
			if (state != ACC_READ_WAIT || read_done) begin
				read_cycle <= '0;
			end else begin
				read_cycle <= read_cycle + 1'b1;
			end

			// counts only while the write is held
			if (state != ACC_WRITE || write_done) begin
				write_cycle <= '0;
			end else begin
				write_cycle <= write_cycle + 1'b1;
			end

			// processor wrote the watched word
			if (state == ACC_PREPARE_WRITE && req_ram_addr == watch_addr) begin
				watch_data <= req.wdata;
			end
		end
	end

	// write payload taken once per write
	always_ff @(posedge clock) begin
		if (state == ACC_PREPARE_WRITE) begin
			write_data <= req.wdata;
		end
	end

	// ----------------------------------------
	// next state
	// ----------------------------------------
	always_comb begin
		next_state = state;
		case (state)
			ACC_IDLE: begin
				if (enable && req_valid) begin
					next_state = req.write ? ACC_PREPARE_WRITE : ACC_READ_WAIT;
				end
			end
			ACC_READ_WAIT: begin
				// registered ram read needs the extra cycle
				if (read_done) begin
					next_state = ACC_IDLE;
				end
			end
			ACC_PREPARE_WRITE: begin
				next_state = ACC_WRITE;
			end
			ACC_WRITE: begin
				// writes finish through the read wait so the new word comes back
				if (write_done) begin
					next_state = ACC_READ_WAIT;
				end
			end
			default: begin
				next_state = ACC_IDLE;
			end
		endcase
	end

	// ----------------------------------------
	// outputs
	// ----------------------------------------
	assign req_ready = (state == ACC_READ_WAIT) && read_done;
	assign rsp_data  = ram_rdata;
	assign writing   = (state == ACC_WRITE);

	always_comb begin
		ram.addr = req_ram_addr;
		ram.data = write_data;
		ram.we   = (state == ACC_WRITE);
	end

	// ready only while the top grants the ram
	assert property (@(posedge clock) disable iff (reset)
		req_ready |-> enable)
		else $error("mem_access: ready while the ram is not granted");

	// write address comes straight from the held request
	assert property (@(posedge clock) disable iff (reset)
		ram.we |-> enable && $stable(req_ram_addr))
		else $error("mem_access: write without grant or with a moving address");

endmodule

//--- source/cpuctrl.sv
`timescale 1ns/1ns
`include "cpuctrl_cfg.svh"

module cpuctrl (
	input  logic                clock,
	input  logic                reset,

	// processor port
	input  mem_pkg::mem_req_t   cpu_req,
	input  logic                cpu_req_valid,
	output logic                cpu_req_ready,
	output mem_pkg::word_t      cpu_rsp_data,

	output logic                boot_done,
	// watched word as written and as stored
	output mem_pkg::word_t      watch_data,
	output mem_pkg::word_t      watch_ram,
	output sys_pkg::sys_status_t status
);

	import mem_pkg::*;
	import sys_pkg::*;

	sys_state_t state;
	sys_state_t next_state;
	logic       reset_all;

	// ----------------------------------------
	// boot sequence
	// ----------------------------------------
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= RESET_ALL;
		end else begin
			state <= next_state;
		end
	end

	logic copy_finished;

	always_comb begin
		next_state = state;
		case (state)
			RESET_ALL: begin
				next_state = COPY_ROM;
			end
			COPY_ROM: begin
				if (copy_finished) begin
					next_state = RUN_CPU;
				end
			end
			RUN_CPU: begin
				// stays here until the next reset
				next_state = RUN_CPU;
			end
			default: begin
				next_state = RESET_ALL;
			end
		endcase
	end

	// submodules cleared together with the state
	assign reset_all = reset || (state == RESET_ALL);
	assign boot_done = (state == RUN_CPU);

	// ----------------------------------------
	// ram and rom
	// ----------------------------------------
	ram_port_t ram_port1;
	ram_port_t copy_port;
	ram_port_t access_port;
	word_t     ram_rdata1;
	rom_addr_t rom_addr;
	word_t     rom_data;
	logic      access_writing;

	ram_2port #(
		.addr_bits(`CFG_RAM_ADDR_BITS),
		.data_bits(`CFG_DATA_BITS)
	) ram_mod (
		.clock (clock),
		.port1 (ram_port1),
		.rdata1(ram_rdata1),
		// second port parked on the watch address
		.addr2 (ram_addr_t'(`CFG_WATCH_ADDR)),
		.rdata2(watch_ram)
	);

	boot_rom rom_mod (
		.addr(rom_addr),
		.data(rom_data)
	);

	// copier owns port 1 during boot
	memcpy #(
		.num_words(`CFG_ROM_WORDS)
	) memcpy_mod (
		.clock   (clock),
		.reset   (reset_all),
		.rom_addr(rom_addr),
		.rom_data(rom_data),
		.ram     (copy_port),
		.finished(copy_finished)
	);

	// processor owns port 1 afterwards
	mem_access access_mod (
		.clock     (clock),
		.reset     (reset_all),
		.enable    (state == RUN_CPU),
		.req       (cpu_req),
		.req_valid (cpu_req_valid),
		.req_ready (cpu_req_ready),
		.ram       (access_port),
		.ram_rdata (ram_rdata1),
		.rsp_data  (cpu_rsp_data),
		.watch_data(watch_data),
		.writing   (access_writing)
	);

	// ----------------------------------------
	// port 1 select
	// ----------------------------------------
	// nobody drives the ram while in reset
	always_comb begin
		case (state)
			COPY_ROM: ram_port1 = copy_port;
			RUN_CPU:  ram_port1 = access_port;
			default:  ram_port1 = '0;
		endcase
	end

	assign status = '{state: state, writing: access_writing};

	// boot only completes after the copy
	assert property (@(posedge clock) disable iff (reset)
		boot_done |-> copy_finished)
		else $error("cpuctrl: boot_done without finished copy");

endmodule

//--- test/cpuctrl_tb_checks.svh
`ifndef CPUCTRL_TB_CHECKS_SVH
`define CPUCTRL_TB_CHECKS_SVH

// ----------------------------------------
// typed compares
// ----------------------------------------
task automatic compare_word(input string name, input word_t actual, input word_t expected);
	if (actual !== expected) begin
		$display("mismatch at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
		err_count++;
	end
endtask

task automatic compare_state(input string name, input sys_state_t actual,
		input sys_state_t expected);
	if (actual !== expected) begin
		$display("mismatch at %0t ns: %s is %s (%0d), expected %s (%0d)", $time, name,
			actual.name(), actual, expected.name(), expected);
		err_count++;
	end
endtask

task automatic compare_flag(input string name, input logic actual, input logic expected);
	if (actual !== expected) begin
		$display("mismatch at %0t ns: %s is %b, expected %b", $time, name, actual, expected);
		err_count++;
	end
endtask

// cycle and pulse counts
task automatic compare_count(input string name, input int actual, input int expected);
	if (actual != expected) begin
		$display("mismatch at %0t ns: %s is %0d, expected %0d", $time, name, actual, expected);
		err_count++;
	end
endtask

// ----------------------------------------
// random source
// ----------------------------------------
// galois form, right shift, taps 32 22 2 1
function automatic logic [31:0] next_lfsr(input logic [31:0] s);
	return (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h0);
endfunction

// one lfsr step per bit taken
function automatic logic [31:0] random_bits(input int n);
	logic [31:0] value;
	value = '0;
	for (int i = 0; i < n; i++) begin
		value = {value[30:0], lfsr_state[0]};
		lfsr_state = next_lfsr(lfsr_state);
	end
	return value;
endfunction

// ----------------------------------------
// waits, each bounded
// ----------------------------------------
// polls boot_done at falling edges
task automatic wait_boot(input int limit, output bit ok, output int cycles);
	cycles = 0;
	while (boot_done !== 1'b1 && cycles < limit) begin
		@(negedge clock);
		cycles++;
	end
	ok = (boot_done === 1'b1);
endtask

// edges counted up to and including the accepting one
// returns at the drive point after that edge
task automatic wait_ready(input int limit, output bit ok, output int edges,
		output int hold_cycles, output word_t data, output word_t watch_d,
		output word_t watch_r);
	ok          = 1'b0;
	edges       = 0;
	hold_cycles = 0;
	data        = '0;
	watch_d     = '0;
	watch_r     = '0;
	while (!ok && edges < limit) begin
		@(negedge clock);
		if (cpu_req_ready === 1'b1) begin
			ok      = 1'b1;
			data    = cpu_rsp_data;
			watch_d = watch_data;
			watch_r = watch_ram;
			accepted++;
		end else if (status.writing === 1'b1) begin
			hold_cycles++;
		end
		@(posedge clock);
		edges++;
	end
	#5;
endtask

`endif

//--- test/cpuctrl_tb.sv
`timescale 1ns/1ns
`include "cpuctrl_cfg.svh"

module cpuctrl_tb;

	import mem_pkg::*;
	import sys_pkg::*;

	// request timing, counted in clock edges
	localparam int read_edges  = 3;
	localparam int write_edges = 7;
	localparam int write_hold  = `CFG_WRITE_CYCLES + 1;
	localparam int ready_limit = 20;
	localparam int boot_limit  = 100;
	localparam int ram_words   = 1 << `CFG_RAM_ADDR_BITS;
	localparam logic [8:0] watch_word = 9'h1ff;

	// row operations
	localparam logic [1:0] op_read  = 2'd0;
	localparam logic [1:0] op_write = 2'd1;
	localparam logic [1:0] op_reset = 2'd2;

	// one stimulus row with its expected results
	typedef struct packed {
		logic [1:0] op;
		addr_t      addr;
		word_t      wdata;
		word_t      expect_data;
		word_t      expect_watch;
		logic       check_watch_ram;
		word_t      expect_watch_ram;
		logic [3:0] group;
	} row_t;

	logic        clock;
	logic        reset;
	mem_req_t    cpu_req;
	logic        cpu_req_valid;
	logic        cpu_req_ready;
	word_t       cpu_rsp_data;
	logic        boot_done;
	word_t       watch_data;
	word_t       watch_ram;
	sys_status_t status;

	int          err_count    = 0;
	int          accepted     = 0;
	int          ready_pulses = 0;
	int          tests_run    = 0;
	int          tests_failed = 0;
	bit          timed_out    = 0;
	logic [31:0] lfsr_state   = 32'hc41b8ed5;

	// reference memory
	word_t       model [ram_words];
	bit          known [ram_words];
	word_t       model_watch;
	row_t        table_q [$];
	string       group_name [6];

	`include "cpuctrl_tb_checks.svh"

	cpuctrl UUT (
		.clock        (clock),
		.reset        (reset),
		.cpu_req      (cpu_req),
		.cpu_req_valid(cpu_req_valid),
		.cpu_req_ready(cpu_req_ready),
		.cpu_rsp_data (cpu_rsp_data),
		.boot_done    (boot_done),
		.watch_data   (watch_data),
		.watch_ram    (watch_ram),
		.status       (status)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// count every ready cycle and flag any before boot
	always @(negedge clock) begin
		if (cpu_req_ready === 1'b1) begin
			ready_pulses++;
			if (boot_done !== 1'b1) begin
				$display("error at %0t ns: ready raised while boot not done", $time);
				err_count++;
			end
		end
	end

	// ----------------------------------------
	// reference model
	// ----------------------------------------
	// high byte address and low byte inverted address
	function automatic word_t boot_word(input int a);
		logic [7:0] b;
		b = a[7:0];
		return {b, ~b};
	endfunction

	task automatic load_boot_model();
		for (int i = 0; i < (1 << `CFG_ROM_ADDR_BITS); i++) begin
			model[i] = boot_word(i);
			known[i] = 1'b1;
		end
		model_watch = '0;
	endtask

	function automatic row_t blank_row(input logic [1:0] op, input addr_t addr,
			input int group);
		row_t r;
		r                  = '0;
		r.op               = op;
		r.addr             = addr;
		r.group            = group[3:0];
		r.expect_watch     = model_watch;
		r.check_watch_ram  = known[watch_word];
		r.expect_watch_ram = model[watch_word];
		return r;
	endfunction

	task automatic add_read(input addr_t addr, input int group);
		row_t r;
		r             = blank_row(op_read, addr, group);
		r.expect_data = model[addr[8:0]];
		table_q.push_back(r);
	endtask

	// upper address bits wrap away
	task automatic add_write(input addr_t addr, input word_t data, input int group);
		row_t r;
		model[addr[8:0]] = data;
		known[addr[8:0]] = 1'b1;
		if (addr[8:0] == watch_word) begin
			model_watch = data;
		end
		r             = blank_row(op_write, addr, group);
		r.wdata       = data;
		r.expect_data = data;
		table_q.push_back(r);
	endtask

	// ram survives reset and the boot copy rewrites the low words
	task automatic add_reset(input int group);
		load_boot_model();
		table_q.push_back(blank_row(op_reset, '0, group));
	endtask

	task automatic build_table();
		addr_t a;
		load_boot_model();
		group_name[0] = "boot image";
		group_name[1] = "write readback and wrap";
		group_name[2] = "watch register";
		group_name[3] = "random access";
		group_name[4] = "reset in mid-run";
		group_name[5] = "boot image after reset";
		for (int i = 0; i < 64; i++) begin
			add_read(addr_t'(i), 0);
		end
		add_write(16'h0040, 16'h1234, 1);
		add_read(16'h0040, 1);
		add_write(16'h0123, 16'hbeef, 1);
		add_write(16'h01fe, 16'h55aa, 1);
		add_read(16'h0123, 1);
		add_read(16'h01fe, 1);
		// multiples of 512 above word 5 and word 80
		add_write(16'h0205, 16'hc0de, 1);
		add_read(16'h0005, 1);
		add_write(16'h0a80, 16'h0f0f, 1);
		add_read(16'h0080, 1);
		add_write(16'h03ff, 16'ha5a5, 2);
		add_write(16'h0100, 16'h7777, 2);
		add_read(16'h01ff, 2);
		add_write(16'h01ff, 16'h3c3c, 2);
		add_write(16'hffff, 16'h9001, 2);
		add_read(16'h03ff, 2);
		// random writes read back through another alias
		for (int k = 0; k < 8; k++) begin
			a = addr_t'(random_bits(16));
			add_write(a, word_t'(random_bits(16)), 3);
			add_read({7'(random_bits(7)), a[8:0]}, 3);
		end
		add_reset(4);
		for (int i = 0; i < 64; i++) begin
			add_read(addr_t'(i), 5);
		end
		add_read(16'h0123, 5);
	endtask

	// ----------------------------------------
	// row application
	// ----------------------------------------
	task automatic report_test(input string name, input int start_errs);
		tests_run++;
		if (err_count == start_errs) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, err_count - start_errs);
		end
	endtask

	// reset held for 8 rising edges and released after the last one
	task automatic hold_reset();
		cpu_req_valid = 1'b0;
		reset         = 1'b1;
		repeat (7) @(posedge clock);
		@(negedge clock);
		compare_flag("cpu_req_ready", cpu_req_ready, 1'b0);
		compare_flag("boot_done", boot_done, 1'b0);
		compare_flag("status.writing", status.writing, 1'b0);
		compare_word("watch_data", watch_data, '0);
		compare_state("status.state", status.state, RESET_ALL);
		@(posedge clock);
		#5;
		reset = 1'b0;
	endtask

	task automatic check_boot();
		bit ok;
		int cycles;
		wait_boot(boot_limit, ok, cycles);
		if (!ok) begin
			$display("error at %0t ns: boot_done not high within %0d cycles", $time, cycles);
			err_count++;
			timed_out = 1'b1;
		end else begin
			compare_state("status.state", status.state, RUN_CPU);
		end
	endtask

	task automatic run_access(input row_t r);
		bit    ok;
		int    edges;
		int    hold;
		word_t data;
		word_t wd;
		word_t wr;
		cpu_req.addr  = r.addr;
		cpu_req.wdata = r.wdata;
		cpu_req.write = (r.op == op_write);
		cpu_req_valid = 1'b1;
		wait_ready(ready_limit, ok, edges, hold, data, wd, wr);
		cpu_req_valid = 1'b0;
		if (!ok) begin
			$display("error at %0t ns: no ready within %0d cycles for address %h",
				$time, ready_limit, r.addr);
			err_count++;
			timed_out = 1'b1;
		end else begin
			compare_word("cpu_rsp_data", data, r.expect_data);
			compare_word("watch_data", wd, r.expect_watch);
			if (r.check_watch_ram) begin
				compare_word("watch_ram", wr, r.expect_watch_ram);
			end
			compare_count("request edges", edges, cpu_req.write ? write_edges : read_edges);
			compare_count("write hold cycles", hold, cpu_req.write ? write_hold : 0);
		end
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------
	initial begin
		row_t  row;
		int    start_errs;
		bit    ok;
		int    edges;
		int    hold;
		word_t data;
		word_t wd;
		word_t wr;

		reset         = 1'b1;
		cpu_req       = '0;
		cpu_req_valid = 1'b0;
		build_table();

		// boot with a read held through the copy
		start_errs = err_count;
		hold_reset();
		cpu_req.addr  = 16'h0000;
		cpu_req.write = 1'b0;
		cpu_req_valid = 1'b1;
		check_boot();
		if (!timed_out) begin
			wait_ready(ready_limit, ok, edges, hold, data, wd, wr);
			cpu_req_valid = 1'b0;
			if (!ok) begin
				$display("error at %0t ns: held boot request never got ready", $time);
				err_count++;
				timed_out = 1'b1;
			end else begin
				compare_word("cpu_rsp_data", data, boot_word(0));
			end
		end
		report_test("boot", start_errs);

		// table loop with one report per group
		start_errs = err_count;
		for (int i = 0; i < table_q.size() && !timed_out; i++) begin
			row = table_q[i];
			if (row.op == op_reset) begin
				hold_reset();
				check_boot();
				@(posedge clock);
				#5;
			end else begin
				run_access(row);
			end
			if (timed_out || i == table_q.size() - 1 || table_q[i + 1].group != row.group) begin
				report_test(group_name[row.group], start_errs);
				start_errs = err_count;
			end
		end

		// one ready cycle per accepted request
		start_errs = err_count;
		compare_count("ready pulses", ready_pulses, accepted);
		report_test("handshake", start_errs);

		$display("summary: %0d tests, %0d failed, %0d errors, %0d requests",
			tests_run, tests_failed, err_count, accepted);
		if (err_count == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

//--- vlog.f
+incdir+common
+incdir+test
common/mem_pkg.sv
common/sys_pkg.sv
memory/ram_2port.sv
memory/boot_rom.sv
memory/memcpy.sv
source/mem_access.sv
source/cpuctrl.sv
test/cpuctrl_tb.sv
